/* run_sim.sh */
#!/usr/bin/env bash
# Build tb_sap_top with Verilator, run it, decide pass or fail from the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG" build.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_sap_top \
    -f sap_top.f -o tb_sap_top > build.log 2>&1 \
    && ./obj_dir/tb_sap_top +verilator+error+limit+100 > "$LOG" 2>&1 \
    || { cat build.log; echo "build or simulation returned an error"; }

[ -f "$LOG" ] && cat "$LOG"

grep -q "^sim passed$" "$LOG" 2>/dev/null \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

/* sap_control.sv */
`default_nettype none

`include "sap_defines.svh"

module sap_control
    import sap_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic prog_mode,        // Hold idle while RAM is loaded
    input  wire opcode_e opcode,        // From IR, valid from T3 on
    output logic      pc_inc,           // PC count enable
    output logic      pc_en,            // PC onto bus
    output logic      pc_load,          // PC from bus
    output logic      mar_addr_load_n,  // MAR address from bus
    output logic      mar_mem_load_n,   // MAR data latch from bus
    output logic      ram_en_n,         // RAM word onto bus
    output logic      ram_load_n,       // RAM write from data latch
    output logic      ir_load_n,        // IR from bus
    output logic      ir_en_n,          // IR address onto bus
    output logic      rega_load_n,      // A from bus
    output logic      rega_en,          // A onto bus
    output logic      sub,              // Adder in subtract mode
    output logic      regb_en,          // Adder result onto bus
    output logic      regb_load_n,      // B from bus
    output logic      out_load_n,       // Output register from bus
    output logic      halted            // HLT reached, level
);

    localparam stage_e LAST_STAGE = stage_e'(`SAP_STAGES - 1);

    stage_e stage;  // Current micro-operation stage

    // HLT only takes effect once the IR holds it
    assign halted = (stage == T3) && (opcode == OP_HLT);

    // Stage moves on the falling edge so strobes settle before the rising edge
    always_ff @(negedge clk) begin
        if (!rst_n) begin
            stage <= T_IDLE;
        end else if (halted) begin
            stage <= T3;  // Frozen until reset
        end else if (prog_mode) begin
            stage <= T_IDLE;
        end else if (stage == T_IDLE) begin
            stage <= T0;
        end else if (stage == LAST_STAGE) begin
            stage <= T_IDLE;
        end else begin
            stage <= stage_e'(stage + 3'd1);
        end
    end

    // Micro-operation decode, only asserted strobes listed per stage
    always_comb begin
        pc_inc          = 1'b0;
        pc_en           = 1'b0;
        pc_load         = 1'b0;
        mar_addr_load_n = 1'b1;
        mar_mem_load_n  = 1'b1;
        ram_en_n        = 1'b1;
        ram_load_n      = 1'b1;
        ir_load_n       = 1'b1;
        ir_en_n         = 1'b1;
        rega_load_n     = 1'b1;
        rega_en         = 1'b0;
        sub             = 1'b0;
        regb_en         = 1'b0;
        regb_load_n     = 1'b1;
        out_load_n      = 1'b1;
        case (stage)
            T0: begin
                pc_en           = 1'b1;  // PC to MAR
                mar_addr_load_n = 1'b0;
            end
            T1: begin
                pc_inc = 1'b1;  // Every instruction, HLT included
            end
            T2: begin
                ram_en_n  = 1'b0;  // Instruction fetch
                ir_load_n = 1'b0;
            end
            T3: begin
                case (opcode)
                    OP_ADD, OP_SUB, OP_LDA, OP_STA: begin
                        ir_en_n         = 1'b0;  // Operand address to MAR
                        mar_addr_load_n = 1'b0;
                    end
                    OP_OUT: begin
                        rega_en    = 1'b1;
                        out_load_n = 1'b0;
                    end
                    OP_JMP: begin
                        ir_en_n = 1'b0;
                        pc_load = 1'b1;
                    end
                    default: ;  // HLT, NOP and undefined codes
                endcase
            end
            T4: begin
                case (opcode)
                    OP_ADD, OP_SUB: begin
                        ram_en_n    = 1'b0;  // Operand into B
                        regb_load_n = 1'b0;
                    end
                    OP_LDA: begin
                        ram_en_n    = 1'b0;
                        rega_load_n = 1'b0;
                    end
                    OP_STA: begin
                        rega_en        = 1'b1;  // A into data latch
                        mar_mem_load_n = 1'b0;
                    end
                    default: ;
                endcase
            end
            T5: begin
                case (opcode)
                    OP_ADD: begin
                        regb_en     = 1'b1;  // Sum back into A
                        rega_load_n = 1'b0;
                    end
                    OP_SUB: begin
                        sub         = 1'b1;
                        regb_en     = 1'b1;
                        rega_load_n = 1'b0;
                    end
                    OP_STA: begin
                        ram_load_n = 1'b0;  // Latch written to RAM
                    end
                    default: ;
                endcase
            end
            default: ;  // Idle drives nothing
        endcase
    end

endmodule

`default_nettype wire

/* sap_defines.svh */
`ifndef SAP_DEFINES_SVH
`define SAP_DEFINES_SVH

// Bus, accumulator and RAM word width
`define SAP_DATA_W 8

// Address width of PC, MAR and IR operand field
`define SAP_ADDR_W 4

// Words of program and data memory
`define SAP_RAM_DEPTH 16

// Micro-operation stages per instruction, T0 to T5
`define SAP_STAGES 6

`endif

/* sap_execute.sv */
`default_nettype none

`include "sap_defines.svh"

module sap_execute (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic [`SAP_DATA_W-1:0] bus,
    input  wire logic                   rega_load_n,  // A from bus
    input  wire logic                   regb_load_n,  // B from bus
    input  wire logic                   sub,          // Adder mode select
    input  wire logic                   out_load_n,   // Output register from bus
    output logic      [`SAP_DATA_W-1:0] rega_value,
    output logic      [`SAP_DATA_W-1:0] alu_value,
    output logic      [`SAP_DATA_W-1:0] out_value,
    output logic                        out_valid
);

    logic [`SAP_DATA_W-1:0] rega;  // Accumulator
    logic [`SAP_DATA_W-1:0] regb;  // Operand register

    // Accumulator, also the adder's destination
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rega <= '0;
        end else if (!rega_load_n) begin
            rega <= bus;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regb <= '0;
        end else if (!regb_load_n) begin
            regb <= bus;
        end
    end

    // Result truncated to bus width, so both directions wrap mod 256
    always_comb begin
        if (sub) begin
            alu_value = rega - regb;
        end else begin
            alu_value = rega + regb;
        end
    end

    // Output register holds its value between OUT instructions
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_value <= '0;
        end else if (!out_load_n) begin
            out_value <= bus;
        end
    end

    // Valid in the cycle after the load edge, strobe lasts one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= ~out_load_n;
        end
    end

    assign rega_value = rega;

endmodule

`default_nettype wire

/* sap_fetch.sv */
`default_nettype none

`include "sap_defines.svh"

module sap_fetch
    import sap_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic [`SAP_DATA_W-1:0] bus,
    input  wire logic                   pc_inc,
    input  wire logic                   pc_en,
    input  wire logic                   pc_load,
    input  wire logic                   mar_addr_load_n,
    input  wire logic                   mar_mem_load_n,
    input  wire logic                   ram_en_n,
    input  wire logic                   ram_load_n,
    input  wire logic                   ir_load_n,
    input  wire logic                   ir_en_n,
    input  wire logic                   prog_mode,
    input  wire logic                   prog_we,
    input  wire logic [`SAP_ADDR_W-1:0] prog_addr,
    input  wire logic [`SAP_DATA_W-1:0] prog_data,
    output logic      [`SAP_ADDR_W-1:0] pc_value,
    output logic      [`SAP_DATA_W-1:0] ram_data,
    output logic      [`SAP_ADDR_W-1:0] ir_addr,
    output opcode_e                     opcode
);

    logic [`SAP_ADDR_W-1:0] pc;
    logic [`SAP_ADDR_W-1:0] mar;                        // Memory address register
    logic [`SAP_DATA_W-1:0] mdr;                        // MAR data latch for STA
    logic [`SAP_DATA_W-1:0] ram [`SAP_RAM_DEPTH];
    mem_word_u              ir;

    // PC, jump load wins over count
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (pc_load) begin
            pc <= bus[`SAP_ADDR_W-1:0];
        end else if (pc_inc) begin
            pc <= pc + 1'b1;  // Wraps at 16
        end
    end

    // Address and data latches feeding the RAM
    always_ff @(posedge clk) begin
        if (!mar_addr_load_n) begin
            mar <= bus[`SAP_ADDR_W-1:0];
        end
        if (!mar_mem_load_n) begin
            mdr <= bus;
        end
    end

    // Program port owns the RAM in load mode
    always_ff @(posedge clk) begin
        if (prog_mode) begin
            if (prog_we) begin
                ram[prog_addr] <= prog_data;
            end
        end else if (!ram_load_n) begin
            ram[mar] <= mdr;
        end
    end

    // Loaded as a data byte, decoded as an instruction
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ir.instr.opcode <= OP_NOP;
            ir.instr.addr   <= '0;
        end else if (!ir_load_n) begin
            ir.data <= bus;
        end
    end

    assign ram_data = ram[mar];          // Asynchronous read
    assign pc_value = pc;
    assign ir_addr  = ir.instr.addr;
    assign opcode   = ir.instr.opcode;

endmodule

`default_nettype wire

/* sap_pkg.sv */
`default_nettype none

`include "sap_defines.svh"

package sap_pkg;

    // Upper nibble of an instruction word
    typedef enum logic [3:0] {
        OP_HLT = 4'h0,  // Freeze sequencer at T3
        OP_NOP = 4'h1,
        OP_ADD = 4'h2,  // A <= A + mem
        OP_SUB = 4'h3,  // A <= A - mem
        OP_LDA = 4'h4,  // A <= mem
        OP_OUT = 4'h5,  // Output <= A
        OP_STA = 4'h6,  // mem <= A
        OP_JMP = 4'h7   // PC <= addr
    } opcode_e;

    // Sequencer states, idle sits between instructions
    typedef enum logic [2:0] {
        T0     = 3'd0,
        T1     = 3'd1,
        T2     = 3'd2,
        T3     = 3'd3,
        T4     = 3'd4,
        T5     = 3'd5,
        T_IDLE = 3'd6
    } stage_e;

    // Same RAM byte seen as instruction or as plain data
    typedef union packed {
        struct packed {
            opcode_e                 opcode;  // Upper nibble
            logic [`SAP_ADDR_W-1:0]  addr;    // Operand address
        } instr;
        logic [`SAP_DATA_W-1:0] data;
    } mem_word_u;

endpackage

`default_nettype wire

/* sap_tests.txt */
# P addr data : RAM word (hex), E value : next expected output (hex)
# R : reset, load the words above, run to HLT and check the outputs
# LDA then OUT twice, OUT after HLT must stay silent
P 0 4E
P 1 50
P 2 50
P 3 00
P 4 50
P E 5A
E 5A
E 5A
R
# ADD and SUB wrapping above 255 and below zero
P 0 4D
P 1 2E
P 2 50
P 3 3F
P 4 50
P 5 2E
P 6 50
P 7 00
P D F0
P E 20
P F 30
E 10
E E0
E 00
R
# STA then LDA back from the stored address
P 0 4D
P 1 2E
P 2 6F
P 3 4E
P 4 50
P 5 4F
P 6 50
P 7 00
P D 37
P E 05
E 05
E 3C
R
# JMP over an OUT and a HLT
P 0 4E
P 1 50
P 2 75
P 3 50
P 4 00
P 5 2F
P 6 50
P 7 00
P E 99
P F 01
E 99
E 9A
R
# NOP and undefined opcodes 8 to F between two OUTs
P 0 4E
P 1 50
P 2 10
P 3 8F
P 4 9F
P 5 AF
P 6 BF
P 7 CF
P 8 DF
P 9 EF
P A FF
P B 50
P C 00
P E 42
E 42
E 42
R

/* sap_top.f */
+incdir+.
sap_pkg.sv
sap_control.sv
sap_fetch.sv
sap_execute.sv
sap_top.sv
sap_top_assert.sv
tb_sap_top.sv

/* sap_top.sv */
`default_nettype none

`include "sap_defines.svh"

module sap_top
    import sap_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   prog_mode,  // RAM load, sequencer idle
    input  wire logic                   prog_we,
    input  wire logic [`SAP_ADDR_W-1:0] prog_addr,
    input  wire logic [`SAP_DATA_W-1:0] prog_data,
    output logic      [`SAP_DATA_W-1:0] out_value,
    output logic                        out_valid,
    output logic                        halted
);

    localparam int PAD_W = `SAP_DATA_W - `SAP_ADDR_W;

    logic                   pc_inc;
    logic                   pc_en;
    logic                   pc_load;
    logic                   mar_addr_load_n;
    logic                   mar_mem_load_n;
    logic                   ram_en_n;
    logic                   ram_load_n;
    logic                   ir_load_n;
    logic                   ir_en_n;
    logic                   rega_load_n;
    logic                   rega_en;
    logic                   sub;
    logic                   regb_en;
    logic                   regb_load_n;
    logic                   out_load_n;
    opcode_e                opcode;
    logic [`SAP_DATA_W-1:0] bus;
    logic [`SAP_ADDR_W-1:0] pc_value;
    logic [`SAP_ADDR_W-1:0] ir_addr;
    logic [`SAP_DATA_W-1:0] ram_data;
    logic [`SAP_DATA_W-1:0] rega_value;
    logic [`SAP_DATA_W-1:0] alu_value;

    // Bus multiplexer in place of tri-state drivers
    always_comb begin
        if (pc_en) begin
            bus = {{PAD_W{1'b0}}, pc_value};
        end else if (!ram_en_n) begin
            bus = ram_data;
        end else if (!ir_en_n) begin
            bus = {{PAD_W{1'b0}}, ir_addr};  // Address nibble only
        end else if (rega_en) begin
            bus = rega_value;
        end else if (regb_en) begin
            bus = alu_value;  // Adder result
        end else begin
            bus = '0;  // Idle bus reads zero
        end
    end

    sap_control u_control (
        .clk             (clk),
        .rst_n           (rst_n),
        .prog_mode       (prog_mode),
        .opcode          (opcode),
        .pc_inc          (pc_inc),
        .pc_en           (pc_en),
        .pc_load         (pc_load),
        .mar_addr_load_n (mar_addr_load_n),
        .mar_mem_load_n  (mar_mem_load_n),
        .ram_en_n        (ram_en_n),
        .ram_load_n      (ram_load_n),
        .ir_load_n       (ir_load_n),
        .ir_en_n         (ir_en_n),
        .rega_load_n     (rega_load_n),
        .rega_en         (rega_en),
        .sub             (sub),
        .regb_en         (regb_en),
        .regb_load_n     (regb_load_n),
        .out_load_n      (out_load_n),
        .halted          (halted)
    );

    sap_fetch u_fetch (
        .clk             (clk),
        .rst_n           (rst_n),
        .bus             (bus),
        .pc_inc          (pc_inc),
        .pc_en           (pc_en),
        .pc_load         (pc_load),
        .mar_addr_load_n (mar_addr_load_n),
        .mar_mem_load_n  (mar_mem_load_n),
        .ram_en_n        (ram_en_n),
        .ram_load_n      (ram_load_n),
        .ir_load_n       (ir_load_n),
        .ir_en_n         (ir_en_n),
        .prog_mode       (prog_mode),
        .prog_we         (prog_we),
        .prog_addr       (prog_addr),
        .prog_data       (prog_data),
        .pc_value        (pc_value),
        .ram_data        (ram_data),
        .ir_addr         (ir_addr),
        .opcode          (opcode)
    );

    sap_execute u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus         (bus),
        .rega_load_n (rega_load_n),
        .regb_load_n (regb_load_n),
        .sub         (sub),
        .out_load_n  (out_load_n),
        .rega_value  (rega_value),
        .alu_value   (alu_value),
        .out_value   (out_value),
        .out_valid   (out_valid)
    );

endmodule

`default_nettype wire

/* sap_top_assert.sv */
`default_nettype none

module sap_top_assert (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic pc_inc,
    input wire logic pc_en,
    input wire logic pc_load,
    input wire logic mar_addr_load_n,
    input wire logic mar_mem_load_n,
    input wire logic ram_en_n,
    input wire logic ram_load_n,
    input wire logic ir_load_n,
    input wire logic ir_en_n,
    input wire logic rega_load_n,
    input wire logic rega_en,
    input wire logic sub,
    input wire logic regb_en,
    input wire logic regb_load_n,
    input wire logic out_load_n,
    input wire logic halted,
    input wire logic out_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;  // Failed assertions so far

    // Bus multiplexer has one owner at most
    one_driver_a: assert property (@(posedge clk) disable iff (!rst_n)
        $countones({pc_en, ~ram_en_n, ~ir_en_n, rega_en, regb_en}) <= 1)
        else begin
            fail_count++;
            $error("more than one bus driver enabled");
        end

    // Sequencer parked in idle right after reset
    reset_idle_a: assert property (@(posedge clk) !rst_n |=>
        (!pc_inc && !pc_en && !pc_load && !rega_en && !sub && !regb_en
         && mar_addr_load_n && mar_mem_load_n && ram_en_n && ram_load_n
         && ir_load_n && ir_en_n && rega_load_n && regb_load_n && out_load_n
         && !halted && !out_valid))
        else begin
            fail_count++;
            $error("strobes active in the cycle after reset");
        end

    halt_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted)
        else begin
            fail_count++;
            $error("halted dropped without reset");
        end

    valid_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |=> !out_valid)
        else begin
            fail_count++;
            $error("out_valid held for two cycles");
        end

endmodule

bind sap_top sap_top_assert assert_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .pc_inc          (pc_inc),
    .pc_en           (pc_en),
    .pc_load         (pc_load),
    .mar_addr_load_n (mar_addr_load_n),
    .mar_mem_load_n  (mar_mem_load_n),
    .ram_en_n        (ram_en_n),
    .ram_load_n      (ram_load_n),
    .ir_load_n       (ir_load_n),
    .ir_en_n         (ir_en_n),
    .rega_load_n     (rega_load_n),
    .rega_en         (rega_en),
    .sub             (sub),
    .regb_en         (regb_en),
    .regb_load_n     (regb_load_n),
    .out_load_n      (out_load_n),
    .halted          (halted),
    .out_valid       (out_valid)
);

`default_nettype wire

/* tb_sap_top.sv */
`default_nettype none

`include "sap_defines.svh"

module tb_sap_top
    import sap_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES     = 3;
    localparam int MAX_RUN_CYCLES   = 500;  // Bound on the wait for halted
    localparam int HALT_HOLD_CYCLES = 50;

    logic                   clk;
    logic                   rst_n;
    logic                   prog_mode;
    logic                   prog_we;
    logic [`SAP_ADDR_W-1:0] prog_addr;
    logic [`SAP_DATA_W-1:0] prog_data;
    logic [`SAP_DATA_W-1:0] out_value;
    logic                   out_valid;
    logic                   halted;

    logic [`SAP_ADDR_W-1:0] image_addr [$];  // Program words of the current test
    logic [`SAP_DATA_W-1:0] image_data [$];
    logic [`SAP_DATA_W-1:0] expected_q [$];  // Outputs still to come
    logic [`SAP_DATA_W-1:0] last_out;        // Value out_value must hold
    int                     test_num;

    sap_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog_mode (prog_mode),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .out_value (out_value),
        .out_valid (out_valid),
        .halted    (halted)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;  // 10 ns period

    task automatic abort_run(input string why);
        $display("Error at %0t ns: %s", $time, why);
        $display("sim failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        if (dut_i.assert_i.fail_count != 0) begin
            abort_run("a concurrent assertion in the bound checker failed");
        end
    end

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %02h, expected %02h", $time, name, got, exp);
            abort_run("value check failed");
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n     <= 1'b0;
        prog_mode <= 1'b1;  // Sequencer stays idle past reset release
        prog_we   <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic write_word(input logic [`SAP_ADDR_W-1:0] addr,
                              input logic [`SAP_DATA_W-1:0] data);
        @(posedge clk);
        prog_we   <= 1'b1;
        prog_addr <= addr;
        prog_data <= data;
    endtask

    // Random instruction words everywhere, then the program on top
    task automatic load_program();
        mem_word_u word;
        int        a;
        for (a = 0; a < `SAP_RAM_DEPTH; a++) begin
            word.instr.opcode = opcode_e'(4'($urandom));
            word.instr.addr   = 4'($urandom);
            write_word(4'(a), word.data);
        end
        foreach (image_addr[i]) begin
            word.data = image_data[i];
            write_word(image_addr[i], word.data);
        end
        @(posedge clk);
        prog_we   <= 1'b0;
        prog_mode <= 1'b0;  // Fetch starts on the next falling edge
    endtask

    task automatic take_output();
        if (expected_q.size() == 0) begin
            abort_run("output pulse with no expected value left");
        end else begin
            last_out = expected_q.pop_front();
            check_value("out_value", out_value, last_out);
        end
    endtask

    task automatic run_program();
        int cycles;
        cycles = 0;
        while (halted !== 1'b1) begin
            if (cycles >= MAX_RUN_CYCLES) begin
                abort_run("program did not halt within 500 cycles");
            end else begin
                @(posedge clk);
                #1;  // Past the register updates
                cycles++;
                if (out_valid === 1'b1) begin
                    take_output();
                end
            end
        end
        for (cycles = 0; cycles < HALT_HOLD_CYCLES; cycles++) begin
            @(posedge clk);
            #1;
            if (out_valid === 1'b1) begin
                abort_run("output pulse after the program halted");
            end
        end
        check_value("halted", 8'(halted), 8'd1);
        check_value("out_value", out_value, last_out);  // Held since last OUT
        if (expected_q.size() != 0) begin
            abort_run("program halted with expected outputs still missing");
        end
    endtask

    task automatic run_test();
        int n_out;
        n_out = expected_q.size();
        test_num++;
        last_out = '0;  // Output register clears on reset
        apply_reset();
        load_program();
        run_program();
        $display("test %0d done, %0d outputs checked", test_num, n_out);
        image_addr.delete();
        image_data.delete();
        expected_q.delete();
    endtask

    task automatic parse_line(input string line);
        logic [31:0] f1;
        logic [31:0] f2;
        int          n;
        byte         tag;
        tag = 8'h20;
        if (line.len() > 0) begin
            tag = line[0];
        end
        if (tag == "P") begin
            n = $sscanf(line, "P %h %h", f1, f2);
            if (n != 2) begin
                abort_run("bad program line in the test file");
            end else begin
                image_addr.push_back(f1[`SAP_ADDR_W-1:0]);
                image_data.push_back(f2[`SAP_DATA_W-1:0]);
            end
        end else if (tag == "E") begin
            n = $sscanf(line, "E %h", f1);
            if (n != 1) begin
                abort_run("bad expected-value line in the test file");
            end else begin
                expected_q.push_back(f1[`SAP_DATA_W-1:0]);
            end
        end else if (tag == "R") begin
            run_test();
        end
    endtask

    initial begin
        int    fd;
        int    n;
        string line;
        rst_n     = 1'b0;
        prog_mode = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        test_num  = 0;
        last_out  = '0;
        void'($urandom(32'h104f_8f8f));
        fd = $fopen("sap_tests.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open sap_tests.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0) begin
                    parse_line(line);
                end
            end
            $fclose(fd);
            if (test_num > 0 && dut_i.assert_i.fail_count == 0) begin
                $display("sim passed");
                $finish;
            end else begin
                abort_run("assertion failures or no tests in the test file");
            end
        end
    end

endmodule

`default_nettype wire
